// ==== design/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data banks, power of two, picked by pa[3:2]
`define MEM_BANKS 4

// 32-bit words per bank, word index is pa[9:4]
`define BANK_WORDS 64

// page-table entries searched in parallel
`define TLB_ENTRIES 4

`endif

// ==== design/mem_pkg.sv ====
package mem_pkg;

    // operand size of a load or store
    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } byte_type_e;

    typedef enum logic [1:0] {
        EXC_NONE       = 2'd0,
        EXC_ALE        = 2'd1,  // misaligned access
        EXC_PAGE_FAULT = 2'd2   // no window or page-table hit
    } excp_code_e;

    // direct-mapped window split
    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } va_win_t;

    // page-table split, 4 KB pages
    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] poff;
    } va_page_t;

    // same virtual address word, decoded both ways
    typedef union packed {
        va_win_t  win;
        va_page_t page;
    } va_u;

endpackage

// ==== design/addr_trans.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module addr_trans (
    input  logic                              en,
    input  mem_pkg::va_u                      va,
    input  mem_pkg::byte_type_e               byte_type,
    input  logic                              csr_dmw_en,
    input  logic [2:0]                        csr_dmw_vseg,
    input  logic [2:0]                        csr_dmw_pseg,
    input  logic [`TLB_ENTRIES-1:0]           tlb_valid,
    input  logic [`TLB_ENTRIES-1:0][19:0]     tlb_vppn,
    input  logic [`TLB_ENTRIES-1:0][19:0]     tlb_ppn,
    output logic [31:0]                       pa,
    output mem_pkg::excp_code_e               excp_code
);
    import mem_pkg::*;

    logic                    misaligned;
    logic                    dmw_hit;
    logic [`TLB_ENTRIES-1:0] tlb_hit;
    logic [19:0]             tlb_page;

    assign misaligned = (byte_type == HALF_WORD && va.page.poff[0]) ||
                        (byte_type == WORD && va.page.poff[1:0] != 2'b00);

    assign dmw_hit = csr_dmw_en && (va.win.seg == csr_dmw_vseg);

    // all entries compared at once, lowest index wins
    always_comb begin
        tlb_page = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            tlb_hit[i] = tlb_valid[i] && (tlb_vppn[i] == va.page.vpn);
            if (tlb_hit[i]) tlb_page = tlb_ppn[i];
        end
    end

    always_comb begin
        pa        = {tlb_page, va.page.poff};
        excp_code = EXC_NONE;
        if (dmw_hit) pa = {csr_dmw_pseg, va.win.offset};
        if (en) begin
            if (misaligned)                excp_code = EXC_ALE;  // checked before translation
            else if (!dmw_hit && !(|tlb_hit)) excp_code = EXC_PAGE_FAULT;
        end
    end

    // the table loaded from outside must not map one page twice
    always_comb begin
        if (en && !dmw_hit) begin
            a_tlb_unique: assert final ($onehot0(tlb_hit))
                else $error("page %h hits several page-table entries", va.page.vpn);
        end
    end

endmodule

// ==== design/mem1_stage.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem1_stage (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush,
    input  logic                                 in_valid,
    input  logic                                 in_is_mem,
    input  logic                                 in_is_store,
    input  logic                                 in_is_signed,
    input  mem_pkg::byte_type_e                  in_byte_type,
    input  logic [31:0]                          in_addr,
    input  logic [31:0]                          in_store_data,
    input  logic [4:0]                           in_rd,
    input  logic                                 in_is_wr_rd,
    output logic                                 in_ready,
    input  logic                                 csr_dmw_en,
    input  logic [2:0]                           csr_dmw_vseg,
    input  logic [2:0]                           csr_dmw_pseg,
    input  logic [`TLB_ENTRIES-1:0]              tlb_valid,
    input  logic [`TLB_ENTRIES-1:0][19:0]        tlb_vppn,
    input  logic [`TLB_ENTRIES-1:0][19:0]        tlb_ppn,
    output logic [`MEM_BANKS-1:0]                bank_en,
    output logic                                 bank_we,
    output logic [$clog2(`BANK_WORDS)-1:0]       bank_widx,
    output logic [3:0]                           bank_wstrb,
    output logic [31:0]                          bank_wdata,
    output logic                                 m2_valid,
    input  logic                                 m2_ready,
    output logic [4:0]                           m2_rd,
    output logic                                 m2_we,
    output logic                                 m2_is_load,
    output logic                                 m2_is_signed,
    output mem_pkg::byte_type_e                  m2_byte_type,
    output logic [1:0]                           m2_byte_off,
    output logic [$clog2(`MEM_BANKS)-1:0]        m2_bank_sel,
    output logic [31:0]                          m2_data,
    output mem_pkg::excp_code_e                  m2_excp_code,
    output logic [31:0]                          m2_badv,
    output logic                                 fwd_valid,
    output logic [4:0]                           fwd_idx,
    output logic [31:0]                          fwd_data,
    output logic                                 fwd_data_valid
);
    import mem_pkg::*;

    localparam int BSEL_W = $clog2(`MEM_BANKS);
    localparam int WIDX_W = $clog2(`BANK_WORDS);

    logic        r_valid;
    logic        r_is_mem;
    logic        r_is_store;
    logic        r_is_signed;
    byte_type_e  r_byte_type;
    va_u         r_addr;
    logic [31:0] r_store_data;
    logic [4:0]  r_rd;
    logic        r_is_wr_rd;

    logic        mem1_flush;
    logic        mem1_stall;
    logic        rdy_out;
    logic        mem_go;
    logic [31:0] pa;
    excp_code_e  addr_excp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (in_ready) begin
            r_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            r_is_mem     <= in_is_mem;
            r_is_store   <= in_is_store;
            r_is_signed  <= in_is_signed;
            r_byte_type  <= in_byte_type;
            r_addr       <= in_addr;
            r_store_data <= in_store_data;
            r_rd         <= in_rd;
            r_is_wr_rd   <= in_is_wr_rd;
        end
    end

    assign mem1_flush = flush | ~r_valid;
    assign mem1_stall = ~m2_ready;
    assign in_ready   = mem1_flush | ~mem1_stall;
    assign rdy_out    = ~mem1_flush & ~mem1_stall;  // hand-over this cycle

    // forwarding, loads are not resolved yet
    assign fwd_valid      = (r_rd != 5'd0) && r_is_wr_rd && ~mem1_flush;
    assign fwd_idx        = r_rd;
    assign fwd_data       = r_addr;
    assign fwd_data_valid = ~(r_is_mem & ~r_is_store);

    addr_trans u_addr_trans (
        .en        (~mem1_flush & r_is_mem),
        .va        (r_addr),
        .byte_type (r_byte_type),
        .csr_dmw_en,
        .csr_dmw_vseg,
        .csr_dmw_pseg,
        .tlb_valid,
        .tlb_vppn,
        .tlb_ppn,
        .pa,
        .excp_code (addr_excp)
    );

    assign mem_go = rdy_out & r_is_mem & (addr_excp == EXC_NONE);

    always_comb begin
        bank_en = '0;
        if (mem_go) bank_en[pa[2 +: BSEL_W]] = 1'b1;
    end

    assign bank_we   = r_is_store;
    assign bank_widx = pa[2 + BSEL_W +: WIDX_W];

    // data is replicated, the strobes pick the lane
    always_comb begin
        unique case (r_byte_type)
            BYTE: begin
                bank_wdata = {4{r_store_data[7:0]}};
                bank_wstrb = 4'b0001 << pa[1:0];
            end
            HALF_WORD: begin
                bank_wdata = {2{r_store_data[15:0]}};
                bank_wstrb = pa[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                bank_wdata = r_store_data;
                bank_wstrb = 4'b1111;
            end
        endcase
    end

    assign m2_valid     = rdy_out;
    assign m2_rd        = r_rd;
    assign m2_we        = r_is_wr_rd & (addr_excp == EXC_NONE);
    assign m2_is_load   = r_is_mem & ~r_is_store;
    assign m2_is_signed = r_is_signed;
    assign m2_byte_type = r_byte_type;
    assign m2_byte_off  = pa[1:0];
    assign m2_bank_sel  = pa[2 +: BSEL_W];
    assign m2_data      = r_addr;        // alu result for non-memory ops
    assign m2_excp_code = addr_excp;
    assign m2_badv      = r_addr;

    // a bank is only reached with a naturally aligned address
    a_no_excp_access: assert property (@(posedge clk) disable iff (!rst_n)
        |bank_en |-> !((r_byte_type == HALF_WORD && r_addr.page.poff[0]) ||
                       (r_byte_type == WORD && r_addr.page.poff[1:0] != 2'b00)));

endmodule

// ==== design/data_bank.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module data_bank (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           we,
    input  logic [$clog2(`BANK_WORDS)-1:0] widx,
    input  logic [3:0]                     wstrb,
    input  logic [31:0]                    wdata,
    output logic [31:0]                    rdata
);

    logic [31:0] mem [`BANK_WORDS];

    // byte-masked write
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // read word held until the next access to this bank
    always_ff @(posedge clk) begin
        if (en) rdata <= mem[widx];
    end

endmodule

// ==== design/mem2_stage.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem2_stage (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 m2_valid,
    output logic                                 m2_ready,
    input  logic [4:0]                           m2_rd,
    input  logic                                 m2_we,
    input  logic                                 m2_is_load,
    input  logic                                 m2_is_signed,
    input  mem_pkg::byte_type_e                  m2_byte_type,
    input  logic [1:0]                           m2_byte_off,
    input  logic [$clog2(`MEM_BANKS)-1:0]        m2_bank_sel,
    input  logic [31:0]                          m2_data,
    input  mem_pkg::excp_code_e                  m2_excp_code,
    input  logic [31:0]                          m2_badv,
    input  logic [`MEM_BANKS-1:0][31:0]          bank_rdata,
    output logic                                 wb_valid,
    input  logic                                 wb_ready,
    output logic [4:0]                           wb_rd,
    output logic                                 wb_we,
    output logic [31:0]                          wb_data,
    output mem_pkg::excp_code_e                  wb_excp_code,
    output logic [31:0]                          wb_badv
);
    import mem_pkg::*;

    logic                          r_valid;
    logic [4:0]                    r_rd;
    logic                          r_we;
    logic                          r_is_load;
    logic                          r_is_signed;
    byte_type_e                    r_byte_type;
    logic [1:0]                    r_byte_off;
    logic [$clog2(`MEM_BANKS)-1:0] r_bank_sel;
    logic [31:0]                   r_data;
    excp_code_e                    r_excp;
    logic [31:0]                   r_badv;
    logic [31:0]                   rd_shift;
    logic [31:0]                   load_val;

    assign m2_ready = ~r_valid | wb_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) r_valid <= 1'b0;
        else if (m2_ready) r_valid <= m2_valid;
    end

    always_ff @(posedge clk) begin
        if (m2_ready) begin
            r_rd        <= m2_rd;
            r_we        <= m2_we;
            r_is_load   <= m2_is_load;
            r_is_signed <= m2_is_signed;
            r_byte_type <= m2_byte_type;
            r_byte_off  <= m2_byte_off;
            r_bank_sel  <= m2_bank_sel;
            r_data      <= m2_data;
            r_excp      <= m2_excp_code;
            r_badv      <= m2_badv;
        end
    end

    assign rd_shift = bank_rdata[r_bank_sel] >> {r_byte_off, 3'b000};

    always_comb begin
        unique case (r_byte_type)
            BYTE:      load_val = {{24{r_is_signed & rd_shift[7]}}, rd_shift[7:0]};
            HALF_WORD: load_val = {{16{r_is_signed & rd_shift[15]}}, rd_shift[15:0]};
            default:   load_val = rd_shift;
        endcase
    end

    assign wb_valid     = r_valid;
    assign wb_rd        = r_rd;
    assign wb_we        = r_we;
    assign wb_data      = r_is_load ? load_val : r_data;
    assign wb_excp_code = r_excp;
    assign wb_badv      = r_badv;

    // bank read word must also hold while stalled
    a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid &&
            $stable({wb_rd, wb_we, wb_data, wb_excp_code, wb_badv}));

endmodule

// ==== design/mem_sub_top.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_sub_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic                          in_is_mem,
    input  logic                          in_is_store,
    input  logic                          in_is_signed,
    input  mem_pkg::byte_type_e           in_byte_type,
    input  logic [31:0]                   in_addr,
    input  logic [31:0]                   in_store_data,
    input  logic [4:0]                    in_rd,
    input  logic                          in_is_wr_rd,
    output logic                          in_ready,
    input  logic                          csr_dmw_en,
    input  logic [2:0]                    csr_dmw_vseg,
    input  logic [2:0]                    csr_dmw_pseg,
    input  logic [`TLB_ENTRIES-1:0]       tlb_valid,
    input  logic [`TLB_ENTRIES-1:0][19:0] tlb_vppn,
    input  logic [`TLB_ENTRIES-1:0][19:0] tlb_ppn,
    output logic                          wb_valid,
    input  logic                          wb_ready,
    output logic [4:0]                    wb_rd,
    output logic                          wb_we,
    output logic [31:0]                   wb_data,
    output mem_pkg::excp_code_e           wb_excp_code,
    output logic [31:0]                   wb_badv,
    output logic                          fwd_valid,
    output logic [4:0]                    fwd_idx,
    output logic [31:0]                   fwd_data,
    output logic                          fwd_data_valid
);
    import mem_pkg::*;

    logic [`MEM_BANKS-1:0]          bank_en;
    logic                           bank_we;
    logic [$clog2(`BANK_WORDS)-1:0] bank_widx;
    logic [3:0]                     bank_wstrb;
    logic [31:0]                    bank_wdata;
    logic [`MEM_BANKS-1:0][31:0]    bank_rdata;

    logic                           m2_valid;
    logic                           m2_ready;
    logic [4:0]                     m2_rd;
    logic                           m2_we;
    logic                           m2_is_load;
    logic                           m2_is_signed;
    byte_type_e                     m2_byte_type;
    logic [1:0]                     m2_byte_off;
    logic [$clog2(`MEM_BANKS)-1:0]  m2_bank_sel;
    logic [31:0]                    m2_data;
    excp_code_e                     m2_excp_code;
    logic [31:0]                    m2_badv;

    mem1_stage u_mem1 (
        .clk, .rst_n, .flush,
        .in_valid, .in_is_mem, .in_is_store, .in_is_signed, .in_byte_type,
        .in_addr, .in_store_data, .in_rd, .in_is_wr_rd, .in_ready,
        .csr_dmw_en, .csr_dmw_vseg, .csr_dmw_pseg,
        .tlb_valid, .tlb_vppn, .tlb_ppn,
        .bank_en, .bank_we, .bank_widx, .bank_wstrb, .bank_wdata,
        .m2_valid, .m2_ready, .m2_rd, .m2_we, .m2_is_load, .m2_is_signed,
        .m2_byte_type, .m2_byte_off, .m2_bank_sel, .m2_data, .m2_excp_code, .m2_badv,
        .fwd_valid, .fwd_idx, .fwd_data, .fwd_data_valid
    );

    // request lines are shared, only bank_en differs
    for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_bank
        data_bank u_bank (
            .clk,
            .en    (bank_en[i]),
            .we    (bank_we),
            .widx  (bank_widx),
            .wstrb (bank_wstrb),
            .wdata (bank_wdata),
            .rdata (bank_rdata[i])
        );
    end

    mem2_stage u_mem2 (
        .clk, .rst_n,
        .m2_valid, .m2_ready, .m2_rd, .m2_we, .m2_is_load, .m2_is_signed,
        .m2_byte_type, .m2_byte_off, .m2_bank_sel, .m2_data, .m2_excp_code, .m2_badv,
        .bank_rdata,
        .wb_valid, .wb_ready, .wb_rd, .wb_we, .wb_data, .wb_excp_code, .wb_badv
    );

endmodule

// ==== dv/mem_sub_tb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_sub_tb;
    import mem_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_OPS    = 64;
    localparam int OP_BOUND   = 24;  // cycles allowed per operation

    logic clk;
    logic rst_n;
    logic flush;
    logic in_valid;
    logic in_is_mem;
    logic in_is_store;
    logic in_is_signed;
    byte_type_e in_byte_type;
    logic [31:0] in_addr;
    logic [31:0] in_store_data;
    logic [4:0] in_rd;
    logic in_is_wr_rd;
    logic in_ready;
    logic csr_dmw_en;
    logic [2:0] csr_dmw_vseg;
    logic [2:0] csr_dmw_pseg;
    logic [`TLB_ENTRIES-1:0] tlb_valid;
    logic [`TLB_ENTRIES-1:0][19:0] tlb_vppn;
    logic [`TLB_ENTRIES-1:0][19:0] tlb_ppn;
    logic wb_valid;
    logic wb_ready;
    logic [4:0] wb_rd;
    logic wb_we;
    logic [31:0] wb_data;
    excp_code_e wb_excp_code;
    logic [31:0] wb_badv;
    logic fwd_valid;
    logic [4:0] fwd_idx;
    logic [31:0] fwd_data;
    logic fwd_data_valid;

    logic [7:0]  phys_mem [1024];  // model of the 1 KB physical space
    logic [31:0] rng_state;
    logic [71:0] exp_q [$];        // {rd, we, excp, data, badv}
    logic [71:0] got_q [$];

    mem_sub_top u_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // records are sampled well away from both edges
    always @(negedge clk) begin
        #2;
        if (rst_n && wb_valid && wb_ready)
            got_q.push_back({wb_rd, wb_we, wb_excp_code, wb_data, wb_badv});
    end

    initial begin
        #(NUM_OPS * OP_BOUND * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d ns", NUM_OPS * OP_BOUND * CLK_PERIOD);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // returns {excp, pa}
    function automatic logic [33:0] translate(input logic [31:0] va, input byte_type_e bt);
        logic [33:0] r;
        logic        hit;
        r   = {EXC_PAGE_FAULT, 32'h0};
        hit = 1'b0;
        if ((bt == HALF_WORD && va[0]) || (bt == WORD && va[1:0] != 2'b00)) begin
            r = {EXC_ALE, 32'h0};
        end else if (csr_dmw_en && va[31:29] == csr_dmw_vseg) begin
            r = {EXC_NONE, csr_dmw_pseg, va[28:0]};
        end else begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (!hit && tlb_valid[i] && tlb_vppn[i] == va[31:12]) begin
                    r   = {EXC_NONE, tlb_ppn[i], va[11:0]};
                    hit = 1'b1;
                end
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] load_from_model(input logic [9:0] a, input byte_type_e bt,
                                                    input logic sgn);
        logic [15:0] h;
        h = {phys_mem[a + 1], phys_mem[a]};
        case (bt)
            BYTE:      return {{24{sgn & phys_mem[a][7]}}, phys_mem[a]};
            HALF_WORD: return {{16{sgn & h[15]}}, h};
            default:   return {phys_mem[a + 3], phys_mem[a + 2], h};
        endcase
    endfunction

    task automatic store_to_model(input logic [9:0] a, input byte_type_e bt,
                                  input logic [31:0] d);
        phys_mem[a] = d[7:0];
        if (bt != BYTE) phys_mem[a + 1] = d[15:8];
        if (bt == WORD) begin
            phys_mem[a + 2] = d[23:16];
            phys_mem[a + 3] = d[31:24];
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic send_op(input logic is_mem, input logic is_store, input logic is_signed,
                           input byte_type_e bt, input logic [31:0] va,
                           input logic [31:0] sdata, input logic [4:0] rd);
        in_valid      = 1'b1;
        in_is_mem     = is_mem;
        in_is_store   = is_store;
        in_is_signed  = is_signed;
        in_byte_type  = bt;
        in_addr       = va;
        in_store_data = sdata;
        in_rd         = rd;
        in_is_wr_rd   = ~is_store;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue(input logic is_mem, input logic is_store, input logic is_signed,
                         input byte_type_e bt, input logic [31:0] va,
                         input logic [31:0] sdata, input logic [4:0] rd);
        logic [33:0] tr;
        excp_code_e  ex;
        logic        we;
        logic [31:0] data;
        tr   = translate(va, bt);
        ex   = is_mem ? excp_code_e'(tr[33:32]) : EXC_NONE;
        we   = !is_store && ex == EXC_NONE;
        data = va;  // alu result
        if (is_mem && !is_store && we) data = load_from_model(tr[9:0], bt, is_signed);
        if (is_mem && is_store && ex == EXC_NONE) store_to_model(tr[9:0], bt, sdata);
        exp_q.push_back({rd, we, ex, data, va});
        send_op(is_mem, is_store, is_signed, bt, va, sdata, rd);
    endtask

    // waits for every expected record, then compares them in order
    task automatic drain(input string name);
        logic [71:0] e;
        logic [71:0] g;
        while (got_q.size() < exp_q.size()) @(negedge clk);
        repeat (3) @(negedge clk);  // any extra record shows up in the count
        check_eq({name, " record count"}, exp_q.size(), got_q.size());
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            check_eq({name, " rd"}, e[71:67], g[71:67]);
            check_eq({name, " we"}, e[66], g[66]);
            check_eq({name, " excp"}, e[65:64], g[65:64]);
            if (e[66]) check_eq({name, " data"}, e[63:32], g[63:32]);
            if (e[65:64] != EXC_NONE) check_eq({name, " badv"}, e[31:0], g[31:0]);
        end
    endtask

    task automatic store_load_words();
        for (int i = 0; i < 8; i++) issue(1, 1, 0, WORD, 32'h8000_0040 + i * 4, next_rand(), 0);
        issue(0, 0, 0, WORD, next_rand(), 0, 5);
        for (int i = 0; i < 8; i++) issue(1, 0, 0, WORD, 32'h8000_0040 + i * 4, 0, 10 + i);
        issue(0, 0, 0, WORD, next_rand(), 0, 6);
        issue(1, 0, 0, WORD, 32'h2000_0040, 0, 7);  // outside the window, table empty
        drain("word_path");
    endtask

    task automatic merge_partial_stores();
        issue(1, 1, 0, WORD, 32'h8000_0100, next_rand(), 0);
        issue(1, 1, 0, BYTE, 32'h8000_0101, next_rand() | 32'h80, 0);  // negative byte
        issue(1, 1, 0, HALF_WORD, 32'h8000_0102, next_rand() | 32'h8000, 0);
        for (int off = 0; off < 4; off++) begin
            issue(1, 0, 0, BYTE, 32'h8000_0100 + off, 0, 20);
            issue(1, 0, 1, BYTE, 32'h8000_0100 + off, 0, 21);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(1, 0, 0, HALF_WORD, 32'h8000_0100 + off, 0, 22);
            issue(1, 0, 1, HALF_WORD, 32'h8000_0100 + off, 0, 23);
        end
        issue(1, 0, 0, WORD, 32'h8000_0100, 0, 24);
        drain("partial_ext");
    endtask

    task automatic translate_by_pages();
        csr_dmw_en  = 1'b0;
        tlb_valid   = 4'b1011;       // entry 2 stays invalid
        tlb_vppn[0] = 20'h00010;
        tlb_ppn[0]  = 20'h00000;
        tlb_vppn[1] = 20'h00abc;
        tlb_ppn[1]  = 20'h00001;
        tlb_vppn[2] = 20'h00777;
        tlb_ppn[2]  = 20'h00002;
        tlb_vppn[3] = 20'h40000;
        tlb_ppn[3]  = 20'h00003;
        issue(1, 1, 0, WORD, 32'h0001_0200, next_rand(), 0);
        issue(1, 0, 0, WORD, 32'h00ab_c200, 0, 3);
        issue(1, 1, 0, WORD, 32'h0077_7200, next_rand(), 0);  // miss
        issue(1, 0, 0, WORD, 32'h0077_7204, 0, 4);
        issue(1, 0, 0, WORD, 32'h4000_0200, 0, 8);
        issue(1, 0, 0, WORD, 32'h8000_0200, 0, 5);  // window off, no entry for this page
        drain("page_table");
        csr_dmw_en = 1'b1;
    endtask

    task automatic reject_misaligned();
        issue(1, 1, 0, WORD, 32'h8000_0180, next_rand(), 0);
        issue(1, 1, 0, HALF_WORD, 32'h8000_0181, next_rand(), 0);
        issue(1, 1, 0, WORD, 32'h8000_0182, next_rand(), 0);
        issue(1, 0, 0, WORD, 32'h8000_0183, 0, 2);
        issue(1, 0, 1, HALF_WORD, 32'h8000_0185, 0, 2);
        issue(1, 0, 0, WORD, 32'h8000_0180, 0, 2);
        drain("alignment");
    endtask

    task automatic stall_and_flush();
        wb_ready = 1'b0;
        fork
            begin
                issue(0, 0, 0, WORD, next_rand(), 0, 11);
                issue(1, 1, 0, WORD, 32'h8000_01c0, next_rand(), 0);
                issue(1, 0, 0, WORD, 32'h8000_01c0, 0, 12);
                issue(0, 0, 0, WORD, next_rand(), 0, 13);
            end
            begin
                repeat (4) @(negedge clk);
                check_eq("backpressure in_ready", 0, in_ready);
                wb_ready = 1'b1;
            end
        join
        drain("backpressure");
        // the store sits in the first stage for this cycle only
        send_op(1, 1, 0, WORD, 32'h8000_0040, next_rand(), 0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        issue(1, 0, 0, WORD, 32'h8000_0040, 0, 14);
        drain("flush");
    endtask

    task automatic park_in_mem1(input logic is_mem, input logic [31:0] va, input logic [4:0] rd);
        wb_ready = 1'b0;
        issue(0, 0, 0, WORD, next_rand(), 0, 1);
        issue(is_mem, 0, 0, WORD, va, 0, rd);
    endtask

    task automatic probe_forwarding();
        park_in_mem1(0, 32'h1234_5678, 7);
        check_eq("fwd_alu valid", 1, fwd_valid);
        check_eq("fwd_alu idx", 7, fwd_idx);
        check_eq("fwd_alu data", 32'h1234_5678, fwd_data);
        check_eq("fwd_alu data_valid", 1, fwd_data_valid);
        wb_ready = 1'b1;
        drain("fwd_alu");
        park_in_mem1(1, 32'h8000_0044, 9);
        check_eq("fwd_load valid", 1, fwd_valid);
        check_eq("fwd_load idx", 9, fwd_idx);
        check_eq("fwd_load data_valid", 0, fwd_data_valid);
        wb_ready = 1'b1;
        drain("fwd_load");
        park_in_mem1(0, 32'hcafe_0001, 0);
        check_eq("fwd_rd0 valid", 0, fwd_valid);
        wb_ready = 1'b1;
        drain("fwd_rd0");
    endtask

    initial begin
        rng_state     = 32'd6566;
        rst_n         = 1'b0;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_is_mem     = 1'b0;
        in_is_store   = 1'b0;
        in_is_signed  = 1'b0;
        in_byte_type  = WORD;
        in_addr       = '0;
        in_store_data = '0;
        in_rd         = '0;
        in_is_wr_rd   = 1'b0;
        csr_dmw_en    = 1'b1;
        csr_dmw_vseg  = 3'h4;  // 0x8xxx_xxxx maps to physical 0
        csr_dmw_pseg  = 3'h0;
        tlb_valid     = '0;
        tlb_vppn      = '0;
        tlb_ppn       = '0;
        wb_ready      = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_eq("reset in_ready", 1, in_ready);
        check_eq("reset wb_valid", 0, wb_valid);
        check_eq("reset fwd_valid", 0, fwd_valid);
        store_load_words();
        merge_partial_stores();
        translate_by_pages();
        reject_misaligned();
        stall_and_flush();
        probe_forwarding();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/mem_pkg.sv
design/addr_trans.sv
design/mem1_stage.sv
design/data_bank.sv
design/mem2_stage.sv
design/mem_sub_top.sv
dv/mem_sub_tb.sv
